/* Makefile */
SOURCES := $(shell grep -v '^+' flist.f)

obj_dir/VportalTb: flist.f $(SOURCES)
	verilator --binary --timing --assert --top-module portalTb -f flist.f

run: obj_dir/VportalTb
	./obj_dir/VportalTb | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* design/beatFifo.sv */
module beatFifo #(
  parameter int Width = 32,
  parameter int Depth = 2
) (
  input  logic             CLK,
  input  logic             RST_N,
  input  logic [Width-1:0] wrData,
  input  logic             push,
  output logic [Width-1:0] rdData,
  input  logic             pop,
  output logic             full,
  output logic             empty
);
  localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntWidth = $clog2(Depth + 1);

  logic [Width-1:0] mem [Depth];
  logic [PtrWidth-1:0] wrPtr, rdPtr;
  logic [CntWidth-1:0] count;
  logic doPush, doPop;

  assign doPush = push && !full;
  assign doPop = pop && !empty;
  assign full = (count == CntWidth'(Depth));
  assign empty = (count == '0);
  assign rdData = mem[rdPtr];

  always_ff @(posedge CLK) begin
    if (doPush) mem[wrPtr] <= wrData;
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) wrPtr <= (wrPtr == PtrWidth'(Depth - 1)) ? '0 : wrPtr + 1'b1;
      if (doPop) rdPtr <= (rdPtr == PtrWidth'(Depth - 1)) ? '0 : rdPtr + 1'b1;
      if (doPush && !doPop) count <= count + 1'b1;
      else if (doPop && !doPush) count <= count - 1'b1;
    end
  end

endmodule

/* design/burstSplitter.sv */
module burstSplitter #(
  parameter int FifoDepth = 2
) (
  input  logic              CLK,
  input  logic              RST_N,
  input  portalPkg::axiReq_t req,
  input  logic              reqValid,
  output logic              reqReady,
  output portalPkg::beat_t  beat,
  output logic              beatValid,
  input  logic              beatReady
);
  import portalPkg::*;

  axiReq_t head;
  logic reqFull, reqEmpty;
  logic first, take, isLast;
  logic [OffsetWidth-1:0] runOffset, curOffset;
  logic [LenWidth-1:0] remain, curRemain;

  // Address queue, popped with the last beat of the burst
  beatFifo #(
    .Width($bits(axiReq_t)),
    .Depth(FifoDepth)
  ) reqFifo_i (
    .CLK(CLK),
    .RST_N(RST_N),
    .wrData(req),
    .push(reqValid && reqReady),
    .rdData(head),
    .pop(take && isLast),
    .full(reqFull),
    .empty(reqEmpty)
  );

  assign reqReady = !reqFull;
  assign beatValid = !reqEmpty;
  assign take = beatValid && beatReady;

  // First beat comes straight from the queue head
  assign curOffset = first ? head.addr.offset : runOffset;
  assign curRemain = first ? head.len : remain;
  assign isLast = (curRemain == '0);

  always_comb begin
    beat.offset = curOffset;
    beat.id = head.id;
    beat.isControl = (head.addr.page == '0);
    beat.indication = head.addr.indication;
    beat.last = isLast;
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      first <= 1'b1;
      runOffset <= '0;
      remain <= '0;
    end else if (take) begin
      first <= isLast;
      runOffset <= curOffset + OffsetWidth'(4); // Word step, wraps in the page
      remain <= curRemain - 1'b1;
    end
  end

endmodule

/* design/echoUser.sv */
module echoUser #(
  parameter int MsgWords = 4
) (
  input  logic                            CLK,
  input  logic                            RST_N,
  input  logic                            pushRequest,
  input  logic [portalPkg::DataWidth-1:0] requestWord,
  output logic                            notFull,
  input  logic                            popIndication,
  output logic [portalPkg::DataWidth-1:0] indWord,
  output logic                            indPending
);
  import portalPkg::*;

  localparam int CntWidth = $clog2(MsgWords + 1);
  localparam int IdxWidth = (MsgWords > 1) ? $clog2(MsgWords) : 1;

  logic [MsgWords-1:0][DataWidth-1:0] collectBuf, indBuf;
  logic [CntWidth-1:0] wordCount, msgLen, hdrLen, curLen, indCount;
  logic loadPending;

  // Header count clamped to 1..MsgWords
  always_comb begin
    if (requestWord[15:0] == 16'd0) hdrLen = CntWidth'(1);
    else if (requestWord[15:0] > 16'(MsgWords)) hdrLen = CntWidth'(MsgWords);
    else hdrLen = CntWidth'(requestWord[15:0]);
  end

  assign curLen = (wordCount == '0) ? hdrLen : msgLen;
  assign indWord = indBuf[0];
  assign indPending = (indCount != '0);
  assign notFull = !indPending && !loadPending;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      wordCount <= '0;
      msgLen <= '0;
      loadPending <= 1'b0;
      indCount <= '0;
    end else begin
      if (pushRequest) begin
        if (wordCount == '0) msgLen <= hdrLen;
        if (wordCount + 1'b1 == curLen) begin
          wordCount <= '0;
          loadPending <= 1'b1; // Copy out next cycle
        end else begin
          wordCount <= wordCount + 1'b1;
        end
      end
      if (loadPending) begin
        loadPending <= 1'b0;
        indCount <= msgLen;
      end else if (popIndication && indPending) begin
        indCount <= indCount - 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (pushRequest) collectBuf[IdxWidth'(wordCount)] <= requestWord;
    if (loadPending) indBuf <= collectBuf;
    else if (popIndication && indPending) indBuf <= indBuf >> DataWidth; // Next word to front
  end

endmodule

/* design/portalPkg.sv */
package portalPkg;

  localparam int DataWidth = 32;
  localparam int IdWidth = 6;
  localparam int LenWidth = 4;
  localparam int OffsetWidth = 5;

  // Control page registers
  localparam logic [OffsetWidth-1:0] CtrlIntrStatus = 5'h00;
  localparam logic [OffsetWidth-1:0] CtrlIntrEnable = 5'h04;
  localparam logic [OffsetWidth-1:0] CtrlNumTiles = 5'h08;
  localparam logic [OffsetWidth-1:0] CtrlQueueStatus = 5'h0C;
  localparam logic [OffsetWidth-1:0] CtrlPortalId = 5'h10;
  localparam logic [OffsetWidth-1:0] CtrlNumPortals = 5'h14;

  localparam logic [DataWidth-1:0] NumTiles = 32'd1;
  localparam logic [DataWidth-1:0] ReqPortalId = 32'd5;
  localparam logic [DataWidth-1:0] IndPortalId = 32'd6;
  localparam logic [DataWidth-1:0] NumPortals = 32'd2;
  localparam logic [DataWidth-1:0] CtrlDefault = 32'h005A05A0; // Unmapped control offsets

  // Data page registers
  localparam logic [OffsetWidth-1:0] DataIndication = 5'h00;
  localparam logic [OffsetWidth-1:0] DataNotFull = 5'h04;

  typedef struct packed {
    logic                   indication; // Indication portal when set
    logic [6:0]             page;       // Zero is the control page
    logic [OffsetWidth-1:0] offset;
  } portalAddr_t;

  typedef struct packed {
    portalAddr_t         addr;
    logic [IdWidth-1:0]  id;
    logic [LenWidth-1:0] len;
  } axiReq_t;

  typedef struct packed {
    logic [OffsetWidth-1:0] offset;
    logic [IdWidth-1:0]     id;
    logic                   isControl;
    logic                   indication;
    logic                   last;
  } beat_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic [IdWidth-1:0]   id;
    logic                 last;
  } rdBeat_t;

endpackage

/* design/portalReadPath.sv */
module portalReadPath #(
  parameter int FifoDepth = 2
) (
  input  logic                            CLK,
  input  logic                            RST_N,
  input  portalPkg::beat_t                beat,
  input  logic                            beatValid,
  output logic                            beatReady,
  input  logic                            indPending,
  input  logic                            notFull,
  input  logic [portalPkg::DataWidth-1:0] indWord,
  output logic                            popIndication,
  output portalPkg::rdBeat_t              rBeat,
  output logic                            rValid,
  input  logic                            rReady
);
  import portalPkg::*;

  rdBeat_t rdEntry;
  logic [DataWidth-1:0] rdValue;
  logic rFull, rEmpty;
  logic indRead, take;

  // Indication word reads wait for a pending word
  assign indRead = !beat.isControl && beat.indication && (beat.offset == DataIndication);
  assign beatReady = !rFull && !(indRead && !indPending);
  assign take = beatValid && beatReady;
  assign popIndication = take && indRead;

  always_comb begin
    rdValue = '0;
    if (beat.isControl) begin
      case (beat.offset)
        CtrlIntrStatus, CtrlQueueStatus: rdValue = DataWidth'(beat.indication && indPending);
        CtrlNumTiles: rdValue = NumTiles;
        CtrlPortalId: rdValue = beat.indication ? IndPortalId : ReqPortalId;
        CtrlNumPortals: rdValue = NumPortals;
        default: rdValue = CtrlDefault; // Includes the enable register
      endcase
    end else if (beat.indication) begin
      if (beat.offset == DataIndication) rdValue = indWord;
    end else if (beat.offset == DataNotFull) begin
      rdValue = DataWidth'(notFull);
    end
  end

  always_comb begin
    rdEntry.data = rdValue;
    rdEntry.id = beat.id;
    rdEntry.last = beat.last;
  end

  // R channel queue
  beatFifo #(
    .Width($bits(rdBeat_t)),
    .Depth(FifoDepth)
  ) rFifo_i (
    .CLK(CLK),
    .RST_N(RST_N),
    .wrData(rdEntry),
    .push(take),
    .rdData(rBeat),
    .pop(rValid && rReady),
    .full(rFull),
    .empty(rEmpty)
  );

  assign rValid = !rEmpty;

endmodule

/* design/portalTop.sv */
module portalTop #(
  parameter int FifoDepth = 2,
  parameter int MsgWords = 4
) (
  input  logic                            CLK,
  input  logic                            RST_N,
  input  portalPkg::portalAddr_t          arAddr,
  input  logic [portalPkg::IdWidth-1:0]   arId,
  input  logic [portalPkg::LenWidth-1:0]  arLen,
  input  logic                            arValid,
  output logic                            arReady,
  output logic [portalPkg::DataWidth-1:0] rData,
  output logic [portalPkg::IdWidth-1:0]   rId,
  output logic                            rLast,
  output logic [1:0]                      rResp,
  output logic                            rValid,
  input  logic                            rReady,
  input  portalPkg::portalAddr_t          awAddr,
  input  logic [portalPkg::IdWidth-1:0]   awId,
  input  logic [portalPkg::LenWidth-1:0]  awLen,
  input  logic                            awValid,
  output logic                            awReady,
  input  logic [portalPkg::DataWidth-1:0] wData,
  input  logic                            wLast,
  input  logic                            wValid,
  output logic                            wReady,
  output logic [portalPkg::IdWidth-1:0]   bId,
  output logic [1:0]                      bResp,
  output logic                            bValid,
  input  logic                            bReady,
  output logic                            interrupt
);
  import portalPkg::*;

  axiReq_t arReq, awReq;
  beat_t rdBeat, wrBeat;
  rdBeat_t rBeat;
  logic rdBeatValid, rdBeatReady, wrBeatValid, wrBeatReady;
  logic notFull, indPending, popIndication, pushRequest;
  logic [DataWidth-1:0] indWord, requestWord;

  assign arReq = '{addr: arAddr, id: arId, len: arLen};
  assign awReq = '{addr: awAddr, id: awId, len: awLen};
  assign rData = rBeat.data;
  assign rId = rBeat.id;
  assign rLast = rBeat.last;
  assign rResp = 2'b00; // Always OKAY
  assign bResp = 2'b00;

  burstSplitter #(.FifoDepth(FifoDepth)) rdSplit_i (
    .CLK(CLK), .RST_N(RST_N), .req(arReq), .reqValid(arValid), .reqReady(arReady),
    .beat(rdBeat), .beatValid(rdBeatValid), .beatReady(rdBeatReady)
  );

  burstSplitter #(.FifoDepth(FifoDepth)) wrSplit_i (
    .CLK(CLK), .RST_N(RST_N), .req(awReq), .reqValid(awValid), .reqReady(awReady),
    .beat(wrBeat), .beatValid(wrBeatValid), .beatReady(wrBeatReady)
  );

  portalReadPath #(.FifoDepth(FifoDepth)) readPath_i (
    .CLK(CLK), .RST_N(RST_N), .beat(rdBeat), .beatValid(rdBeatValid),
    .beatReady(rdBeatReady), .indPending(indPending), .notFull(notFull), .indWord(indWord),
    .popIndication(popIndication), .rBeat(rBeat), .rValid(rValid), .rReady(rReady)
  );

  portalWritePath #(.FifoDepth(FifoDepth)) writePath_i (
    .CLK(CLK), .RST_N(RST_N), .wData(wData), .wLast(wLast), .wValid(wValid),
    .wReady(wReady), .awAccepted(awValid && awReady), .beat(wrBeat),
    .beatValid(wrBeatValid), .beatReady(wrBeatReady), .notFull(notFull),
    .pushRequest(pushRequest), .requestWord(requestWord), .indPending(indPending),
    .interrupt(interrupt), .bId(bId), .bValid(bValid), .bReady(bReady)
  );

  echoUser #(.MsgWords(MsgWords)) echoUser_i (
    .CLK(CLK), .RST_N(RST_N), .pushRequest(pushRequest), .requestWord(requestWord),
    .notFull(notFull), .popIndication(popIndication), .indWord(indWord),
    .indPending(indPending)
  );

endmodule

/* design/portalWritePath.sv */
module portalWritePath #(
  parameter int FifoDepth = 2
) (
  input  logic                            CLK,
  input  logic                            RST_N,
  input  logic [portalPkg::DataWidth-1:0] wData,
  input  logic                            wLast,
  input  logic                            wValid,
  output logic                            wReady,
  input  logic                            awAccepted,
  input  portalPkg::beat_t                beat,
  input  logic                            beatValid,
  output logic                            beatReady,
  input  logic                            notFull,
  output logic                            pushRequest,
  output logic [portalPkg::DataWidth-1:0] requestWord,
  input  logic                            indPending,
  output logic                            interrupt,
  output logic [portalPkg::IdWidth-1:0]   bId,
  output logic                            bValid,
  input  logic                            bReady
);
  import portalPkg::*;

  logic wFull, wEmpty, bFull, bEmpty;
  logic lastSeen, intrEnable;
  logic toUser, take;

  beatFifo #(
    .Width(DataWidth),
    .Depth(FifoDepth)
  ) wFifo_i (
    .CLK(CLK),
    .RST_N(RST_N),
    .wrData(wData),
    .push(wValid && wReady),
    .rdData(requestWord),
    .pop(take),
    .full(wFull),
    .empty(wEmpty)
  );

  assign wReady = !wFull && !lastSeen;

  // Request portal data page goes to the user
  assign toUser = !beat.isControl && !beat.indication;
  assign beatReady = !wEmpty && (!beat.last || !bFull) && (!toUser || notFull);
  assign take = beatValid && beatReady;
  assign pushRequest = take && toUser;

  // One response per burst
  beatFifo #(
    .Width(IdWidth),
    .Depth(FifoDepth)
  ) bFifo_i (
    .CLK(CLK),
    .RST_N(RST_N),
    .wrData(beat.id),
    .push(take && beat.last),
    .rdData(bId),
    .pop(bValid && bReady),
    .full(bFull),
    .empty(bEmpty)
  );

  assign bValid = !bEmpty;
  assign interrupt = indPending && intrEnable;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      lastSeen <= 1'b0;
      intrEnable <= 1'b0;
    end else begin
      if (awAccepted) lastSeen <= 1'b0;
      else if (wValid && wReady && wLast) lastSeen <= 1'b1;
      if (take && beat.isControl && beat.offset == CtrlIntrEnable)
        intrEnable <= requestWord[0];
    end
  end

endmodule

/* flist.f */
design/portalPkg.sv
design/beatFifo.sv
design/burstSplitter.sv
design/portalReadPath.sv
design/portalWritePath.sv
design/echoUser.sv
design/portalTop.sv
verif/portalTb.sv

/* verif/portalTb.sv */
module portalTb;
  timeunit 1ns;
  timeprecision 1ps;
  import portalPkg::*;

  localparam int FifoDepth = 2;
  localparam int MsgWords = 4;
  localparam int NumTests = 5;
  localparam int CyclesPerTest = 400;

  logic CLK, RST_N;
  portalAddr_t arAddr, awAddr;
  logic [IdWidth-1:0] arId, awId, rId, bId;
  logic [LenWidth-1:0] arLen, awLen;
  logic arValid, arReady, rLast, rValid, rReady;
  logic awValid, awReady, wLast, wValid, wReady, bValid, bReady, interrupt;
  logic [DataWidth-1:0] rData, wData;
  logic [1:0] rResp, bResp;

  rdBeat_t expR[$];
  logic [IdWidth-1:0] expB[$];
  logic [DataWidth-1:0] indQ[$]; // Words the echo user still holds
  logic [DataWidth-1:0] msgQ[$]; // Request message being collected
  logic [DataWidth-1:0] words[$];
  int msgLen;
  logic intrEn = 1'b0;
  logic stallOn = 1'b0;
  int seed = 32'h28e7b0aa;
  int errorCount = 0;
  int checkCount = 0;
  int testCount = 0;
  int testStartErrors = 0;

  portalTop #(.FifoDepth(FifoDepth), .MsgWords(MsgWords)) dut_i (.*);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // Ready stalls for R and B
  initial begin
    logic [31:0] rnd;
    rReady = 1'b0;
    bReady = 1'b0;
    forever begin
      @(posedge CLK);
      rnd = $random(seed);
      rReady <= !stallOn || rnd[0];
      bReady <= !stallOn || rnd[1];
    end
  end

  initial begin
    repeat (16 + NumTests * CyclesPerTest) @(posedge CLK);
    $display("Watchdog expired, the tests did not finish within %0d cycles",
             16 + NumTests * CyclesPerTest);
    $display("Done: errors found");
    $finish;
  end

  function automatic logic [DataWidth-1:0] randomWord();
    return $random(seed);
  endfunction

  function automatic portalAddr_t makeAddr(input logic ind, input logic [6:0] page,
                                           input logic [OffsetWidth-1:0] offset);
    portalAddr_t a;
    a.indication = ind;
    a.page = page;
    a.offset = offset;
    return a;
  endfunction

  function automatic int headerCount(input logic [DataWidth-1:0] word);
    int n;
    n = int'(word[15:0]);
    if (n < 1) n = 1;
    if (n > MsgWords) n = MsgWords;
    return n;
  endfunction

  // Reference value of one read beat
  function automatic logic [DataWidth-1:0] modelRead(input portalAddr_t a);
    logic [DataWidth-1:0] v;
    v = '0;
    if (a.page == '0) begin
      case (a.offset)
        CtrlIntrStatus, CtrlQueueStatus: v = DataWidth'(a.indication && indQ.size() != 0);
        CtrlNumTiles: v = 32'd1;
        CtrlPortalId: v = a.indication ? 32'd6 : 32'd5;
        CtrlNumPortals: v = 32'd2;
        default: v = 32'h005A05A0;
      endcase
    end else if (a.indication) begin
      if (a.offset == DataIndication && indQ.size() != 0) v = indQ.pop_front();
    end else if (a.offset == DataNotFull) begin
      v = DataWidth'(indQ.size() == 0);
    end
    return v;
  endfunction

  function automatic void modelWrite(input portalAddr_t a, input logic [DataWidth-1:0] word);
    if (a.page == '0) begin
      if (a.offset == CtrlIntrEnable) intrEn = word[0];
    end else if (!a.indication) begin
      if (msgQ.size() == 0) msgLen = headerCount(word);
      msgQ.push_back(word);
      if (msgQ.size() == msgLen) begin
        indQ = msgQ; // Echoed back whole
        msgQ.delete();
      end
    end
  endfunction

  task automatic checkBit(input string what, input logic got, input logic exp);
    assert (got === exp) checkCount++;
    else begin
      errorCount++;
      $display("error %0t: %s is %0b, expected %0b", $time, what, got, exp);
    end
  endtask

  task automatic axiRead(input portalAddr_t addr, input logic [IdWidth-1:0] id,
                         input logic [LenWidth-1:0] len);
    portalAddr_t a;
    a = addr;
    @(posedge CLK);
    for (int k = 0; k <= int'(len); k++) begin
      expR.push_back('{data: modelRead(a), id: id, last: (k == int'(len))});
      a.offset = a.offset + OffsetWidth'(4);
    end
    arAddr <= addr;
    arId <= id;
    arLen <= len;
    arValid <= 1'b1;
    @(negedge CLK);
    while (!arReady) @(negedge CLK);
    @(posedge CLK);
    arValid <= 1'b0;
  endtask

  task automatic axiWrite(input portalAddr_t addr, input logic [IdWidth-1:0] id,
                          input logic [DataWidth-1:0] data[$]);
    portalAddr_t a;
    a = addr;
    @(posedge CLK);
    foreach (data[k]) begin
      modelWrite(a, data[k]);
      a.offset = a.offset + OffsetWidth'(4);
    end
    expB.push_back(id);
    awAddr <= addr;
    awId <= id;
    awLen <= LenWidth'(data.size() - 1);
    awValid <= 1'b1;
    @(negedge CLK);
    while (!awReady) @(negedge CLK);
    @(posedge CLK);
    awValid <= 1'b0;
    foreach (data[k]) begin
      wData <= data[k];
      wLast <= (k == data.size() - 1);
      wValid <= 1'b1;
      @(negedge CLK);
      while (!wReady) @(negedge CLK);
      @(posedge CLK);
    end
    wValid <= 1'b0;
    wLast <= 1'b0;
  endtask

  task automatic waitIdle();
    while (expR.size() != 0 || expB.size() != 0) @(posedge CLK);
  endtask

  // Header with word count, then random payload
  task automatic sendMessage(input int count, input logic [IdWidth-1:0] id);
    logic [DataWidth-1:0] header;
    words.delete();
    header = randomWord();
    header[15:0] = 16'(count);
    words.push_back(header);
    for (int k = 1; k < count; k++) words.push_back(randomWord());
    axiWrite(makeAddr(1'b0, 7'd1, 5'h00), id, words);
    waitIdle();
  endtask

  task automatic endTest(input string name);
    testCount++;
    if (errorCount == testStartErrors) $display("Test %0d %s: passed", testCount, name);
    else $display("Test %0d %s: %0d errors", testCount, name, errorCount - testStartErrors);
    testStartErrors = errorCount;
  endtask

  // Outputs settle by the falling edge and transfer at the next rising edge
  always @(negedge CLK) begin
    rdBeat_t got;
    if (RST_N && rValid && rReady) begin
      got = '{data: rData, id: rId, last: rLast};
      if (expR.size() == 0) begin
        errorCount++;
        $display("R beat with ID %0d arrived while no read was outstanding", rId);
      end else begin
        assert (got === expR[0]) checkCount++;
        else begin
          errorCount++;
          $display("error %0t: R beat %h id %0d last %0b, expected %h id %0d last %0b",
                   $time, rData, rId, rLast, expR[0].data, expR[0].id, expR[0].last);
        end
        void'(expR.pop_front());
      end
    end
  end

  always @(negedge CLK) begin
    if (RST_N && bValid && bReady) begin
      if (expB.size() == 0) begin
        errorCount++;
        $display("B response with ID %0d arrived while no write was outstanding", bId);
      end else begin
        assert (bId === expB[0]) checkCount++;
        else begin
          errorCount++;
          $display("error %0t: bId %0d, expected %0d", $time, bId, expB[0]);
        end
        void'(expB.pop_front());
      end
    end
  end

  respOkay: assert property (@(negedge CLK) disable iff (!RST_N)
                             rResp == 2'b00 && bResp == 2'b00)
    else begin
      errorCount++;
      $display("error %0t: nonzero R or B response code", $time);
    end

  intrGated: assert property (@(negedge CLK) disable iff (!RST_N) interrupt |-> intrEn)
    else begin
      errorCount++;
      $display("error %0t: interrupt high with the enable cleared", $time);
    end

  rHeld: assert property (@(negedge CLK) disable iff (!RST_N)
                          rValid && !rReady |=> rValid && $stable(rData) && $stable(rId)
                          && $stable(rLast))
    else begin
      errorCount++;
      $display("error %0t: stalled R entry changed", $time);
    end

  bHeld: assert property (@(negedge CLK) disable iff (!RST_N)
                          bValid && !bReady |=> bValid && $stable(bId))
    else begin
      errorCount++;
      $display("error %0t: stalled B entry changed", $time);
    end

  initial begin
    portalAddr_t ctrlInd, indData, reqNotFull, enableAddr;
    ctrlInd = makeAddr(1'b1, 7'd0, CtrlIntrStatus);
    indData = makeAddr(1'b1, 7'd1, DataIndication);
    reqNotFull = makeAddr(1'b0, 7'd1, DataNotFull);
    enableAddr = makeAddr(1'b0, 7'd0, CtrlIntrEnable);
    RST_N = 1'b0;
    arAddr = '0;
    arId = '0;
    arLen = '0;
    arValid = 1'b0;
    awAddr = '0;
    awId = '0;
    awLen = '0;
    awValid = 1'b0;
    wData = '0;
    wLast = 1'b0;
    wValid = 1'b0;
    repeat (16) @(posedge CLK);
    RST_N <= 1'b1;

    @(negedge CLK);
    checkBit("rValid after reset", rValid, 1'b0);
    checkBit("bValid after reset", bValid, 1'b0);
    checkBit("interrupt after reset", interrupt, 1'b0);
    checkBit("arReady after reset", arReady, 1'b1);
    checkBit("awReady after reset", awReady, 1'b1);
    axiRead(makeAddr(1'b0, 7'd0, 5'h00), 6'd1, 4'd7);
    waitIdle();
    endTest("control page burst");

    sendMessage(3, 6'd2);
    @(negedge CLK);
    checkBit("wReady after wLast", wReady, 1'b0); // Held until the next AW
    axiRead(ctrlInd, 6'd3, 4'd0);
    axiRead(reqNotFull, 6'd4, 4'd0);
    waitIdle();
    endTest("request message write");

    repeat (3) axiRead(indData, 6'd5, 4'd0);
    waitIdle();
    axiRead(ctrlInd, 6'd6, 4'd0);
    axiRead(reqNotFull, 6'd6, 4'd0);
    waitIdle();
    endTest("indication readout");

    words.delete();
    words.push_back(32'd1);
    axiWrite(enableAddr, 6'd7, words);
    sendMessage(2, 6'd8);
    @(negedge CLK);
    checkBit("interrupt while words pending", interrupt, 1'b1);
    repeat (2) axiRead(indData, 6'd9, 4'd0);
    waitIdle();
    @(negedge CLK);
    checkBit("interrupt after last pop", interrupt, 1'b0);
    words.delete();
    words.push_back(32'd0);
    axiWrite(enableAddr, 6'd10, words);
    sendMessage(1, 6'd11);
    @(negedge CLK);
    checkBit("interrupt with enable cleared", interrupt, 1'b0);
    axiRead(indData, 6'd12, 4'd0);
    waitIdle();
    endTest("interrupt enable");

    stallOn <= 1'b1;
    axiRead(makeAddr(1'b0, 7'd0, 5'h08), 6'd13, 4'd7); // Offsets wrap in the page
    axiRead(makeAddr(1'b1, 7'd0, 5'h0C), 6'd14, 4'd3);
    words.delete();
    words.push_back(randomWord());
    words.push_back(randomWord());
    axiWrite(makeAddr(1'b1, 7'd1, 5'h00), 6'd15, words); // Dropped by the portal
    words.delete();
    words.push_back(32'd0);
    axiWrite(enableAddr, 6'd16, words);
    axiRead(reqNotFull, 6'd17, 4'd1);
    waitIdle();
    stallOn <= 1'b0;
    endTest("back-pressure");

    $display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
